/* source/fetch_pkg.sv */
/*
  Shared constants for the 16-bit fetch stage.
  The PC is a byte address and instructions are 16-bit words, so PC bit 0 is always 0.
  The predictor is direct-mapped on a few low PC bits and keeps no tags, so aliasing
  PCs share one entry. The image path is relative to the simulator's working directory.
*/
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int addr_w = 16;                    // PC and branch target width
  localparam int inst_w = 16;                    // Instruction word width

  // Opcode sits in the top nibble of the instruction
  localparam int opcode_msb = 15;
  localparam int opcode_w   = 4;
  localparam logic [opcode_w-1:0] halt_opcode = '1;  // HLT is opcode F

  ////////////////////////////////////////////////////////////////////////////
  // Instruction memory
  ////////////////////////////////////////////////////////////////////////////
  localparam int rom_words = 256;                // Words past this read as zero
  localparam int rom_idx_w = $clog2(rom_words);  // Word index width inside the ROM
  localparam string rom_image = "source/program.hex";

  ////////////////////////////////////////////////////////////////////////////
  // Branch predictor
  ////////////////////////////////////////////////////////////////////////////
  // Index taken from PC[pred_idx_w:1]
  localparam int pred_idx_w   = 3;
  localparam int pred_entries = 1 << pred_idx_w;

  // 2-bit saturating counter encoding
  //   00 strongly not taken
  //   01 weakly not taken
  //   10 weakly taken
  //   11 strongly taken
  localparam logic [1:0] counter_reset = 2'b00;  // Start strongly not taken

endpackage

/* source/predict_if.sv */
/*
  Lookup and update signals between the fetch stage and the branch predictor.
  Update fields are only sampled while their write strobe is high.
  Lookup results are combinational from lookup_pc.
*/
`timescale 1ns/1ps

interface predict_if;
  import fetch_pkg::*;

  // Lookup side
  logic [addr_w-1:0] lookup_pc;          // Current PC
  logic              enable;             // Low during a stall
  logic [1:0]        prediction;         // Counter at the lookup index
  logic              predicted_taken;    // Counter MSB
  logic [addr_w-1:0] predicted_target;   // BTB entry at the lookup index

  // Update side, driven by the resolving stage
  logic [addr_w-1:0] update_pc;          // PC of the resolved branch
  logic [1:0]        update_prediction;  // Counter that was predicted for it
  logic              wen_bht;            // History table write strobe
  logic              wen_btb;            // Target buffer write strobe
  logic              resolved_taken;     // Actual outcome
  logic [addr_w-1:0] resolved_target;    // Actual target

  modport fetch (
    output lookup_pc, enable, update_pc, update_prediction,
    output wen_bht, wen_btb, resolved_taken, resolved_target,
    input  prediction, predicted_taken, predicted_target
  );

  modport predictor (
    input  lookup_pc, enable, update_pc, update_prediction,
    input  wen_bht, wen_btb, resolved_taken, resolved_target,
    output prediction, predicted_taken, predicted_target
  );

endinterface

/* source/branch_predictor.sv */
/*
  Direct-mapped BHT of 2-bit saturating counters plus a BTB of full targets.
  No tags, so different PCs with the same low bits alias onto one entry.
  The counter update starts from the prediction carried down the pipe and not from
  the stored counter. A write lands on the next edge and is ignored while enable is low.
*/
`timescale 1ns/1ps

module branch_predictor (
  input logic         clk,
  input logic         rst,
  predict_if.predictor pif
);
  import fetch_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////
  logic [1:0]        bht [pred_entries];  // History counters
  logic [addr_w-1:0] btb [pred_entries];  // Branch targets

  logic [pred_idx_w-1:0] lookup_idx;      // Index for the current PC
  logic [pred_idx_w-1:0] update_idx;      // Index for the resolved PC
  logic [1:0]            next_count;      // Counter value to write back

  // Byte addresses, so skip PC bit 0
  assign lookup_idx = pif.lookup_pc[pred_idx_w:1];
  assign update_idx = pif.update_pc[pred_idx_w:1];

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  // Purely combinational, same cycle as the PC
  assign pif.prediction       = bht[lookup_idx];
  assign pif.predicted_taken  = bht[lookup_idx][1];  // Taken for 10 and 11
  assign pif.predicted_target = btb[lookup_idx];

  ////////////////////////////////////////////////////////////////////////////
  // Counter update
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    next_count = pif.update_prediction;  // Hold when already saturated
    if (pif.resolved_taken) begin
      if (pif.update_prediction != 2'b11) begin
        next_count = pif.update_prediction + 2'd1;  // Step toward taken
      end
    end else begin
      if (pif.update_prediction != 2'b00) begin
        next_count = pif.update_prediction - 2'd1;  // Step toward not taken
      end
    end
  end

  // History table
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < pred_entries; i++) begin
        bht[i] <= counter_reset;
      end
    end else if (pif.enable && pif.wen_bht) begin
      bht[update_idx] <= next_count;
    end
  end

  // Target buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < pred_entries; i++) begin
        btb[i] <= '0;  // Unused targets point at address 0
      end
    end else if (pif.enable && pif.wen_btb) begin
      btb[update_idx] <= pif.resolved_target;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // The resolving stage only writes a target for a branch it also trains
  a_btb_with_bht : assert property (
    @(posedge clk) disable iff (rst)
      $rose(pif.wen_btb) |-> pif.wen_bht
  ) else $error("wen_btb rose without wen_bht");

endmodule

/* source/inst_rom.sv */
/*
  Read-only instruction memory, combinational read.
  Contents come from the hex image at elaboration; a missing file leaves X.
  Word index is addr[15:1]. Words past the array read as 0.
*/
`timescale 1ns/1ps

module inst_rom (
  input  logic                         clk,   // Only samples the check below
  input  logic [fetch_pkg::addr_w-1:0] addr,  // Byte address, expected even
  output logic [fetch_pkg::inst_w-1:0] data
);
  import fetch_pkg::*;

  logic [inst_w-1:0] mem [rom_words];  // ROM contents
  logic [addr_w-2:0] word_idx;         // Address with bit 0 dropped

  initial begin
    $readmemh(rom_image, mem);
  end

  assign word_idx = addr[addr_w-1:1];

  // Out of range reads return zero
  assign data = (word_idx < rom_words) ? mem[word_idx[rom_idx_w-1:0]] : '0;

  // Halfword addresses only
  a_even_addr : assert property (
    @(posedge clk) !$isunknown(addr) |-> !addr[0]
  ) else $error("odd ROM address %h", addr);

endmodule

/* source/fetch_stage.sv */
/*
  Fetch stage of the 16-bit pipeline. PC register, ROM and branch predictor.
  Next PC priority is redirect, then halt hold, then predicted target, then PC + 2.
  Stall freezes the PC, zeroes pc_inst and blocks predictor writes.
  Update ports come straight from the resolving stage and are passed through untouched.
*/
`timescale 1ns/1ps

module fetch_stage (
  input  logic                         clk,
  input  logic                         rst,                  // Sync, active high
  input  logic                         stall,                // From the hazard logic
  input  logic                         update_pc_req,        // Mispredict redirect
  input  logic [fetch_pkg::addr_w-1:0] redirect_target,      // Correct PC on mispredict
  input  logic                         wen_bht,              // Train history counter
  input  logic                         wen_btb,              // Write branch target
  input  logic                         resolved_taken,       // Actual branch outcome
  input  logic [fetch_pkg::addr_w-1:0] resolved_target,      // Actual branch target
  input  logic [fetch_pkg::addr_w-1:0] resolved_pc,          // PC of the resolved branch
  input  logic [1:0]                   resolved_prediction,  // Counter it was fetched with
  output logic [fetch_pkg::addr_w-1:0] pc_curr,
  output logic [fetch_pkg::addr_w-1:0] pc_next,              // Always pc_curr + 2
  output logic [fetch_pkg::inst_w-1:0] pc_inst,
  output logic [1:0]                   prediction,
  output logic [fetch_pkg::addr_w-1:0] predicted_target
);
  import fetch_pkg::*;

  logic [inst_w-1:0] rom_data;      // Raw ROM word at pc_curr
  logic              halt_fetched;  // Current word is HLT
  logic [addr_w-1:0] pc_sel;        // Next PC after priority select

  predict_if pif ();

  ////////////////////////////////////////////////////////////////////////////
  // Predictor hookup
  ////////////////////////////////////////////////////////////////////////////
  assign pif.lookup_pc         = pc_curr;
  assign pif.enable            = ~stall;  // No table writes while stalled
  assign pif.update_pc         = resolved_pc;
  assign pif.update_prediction = resolved_prediction;
  assign pif.wen_bht           = wen_bht;
  assign pif.wen_btb           = wen_btb;
  assign pif.resolved_taken    = resolved_taken;
  assign pif.resolved_target   = resolved_target;

  assign prediction       = pif.prediction;
  assign predicted_target = pif.predicted_target;

  branch_predictor u_predictor (
    .clk (clk),
    .rst (rst),
    .pif (pif.predictor)
  );

  inst_rom u_rom (
    .clk  (clk),
    .addr (pc_curr),
    .data (rom_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////////////
  assign pc_inst      = stall ? '0 : rom_data;  // Bubble during stall
  assign halt_fetched = (pc_inst[opcode_msb -: opcode_w] == halt_opcode);
  assign pc_next      = pc_curr + addr_w'(2);

  always_comb begin
    if (update_pc_req) begin
      pc_sel = redirect_target;        // Mispredict wins over everything
    end else if (halt_fetched) begin
      pc_sel = pc_curr;                // Spin on HLT
    end else if (pif.predicted_taken) begin
      pc_sel = pif.predicted_target;
    end else begin
      pc_sel = pc_next;                // Sequential
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_curr <= '0;
    end else if (!stall) begin
      pc_curr <= pc_sel;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // Catches odd redirect or BTB targets
  a_pc_even : assert property (
    @(posedge clk) disable iff (rst) !pc_curr[0]
  ) else $error("pc_curr went odd: %h", pc_curr);

  a_stall_hold : assert property (
    @(posedge clk) disable iff (rst) stall |=> $stable(pc_curr)
  ) else $error("pc_curr moved across a stall");

endmodule

/* verif/tb_fetch.sv */
/*
  Directed testbench for the fetch stage. Plays the resolving stage through the
  update ports. Expects the image to fit in 24 words with HLT at byte address 40.
  Inputs change 2 ns after a rising edge, outputs are checked at the falling edge.
*/
`timescale 1ns/1ps

module tb_fetch;
  import fetch_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Run length
  ////////////////////////////////////////////////////////////////////////////
  localparam int clk_period     = 20;
  localparam int reset_cycles   = 2;
  localparam int seq_cycles     = 10;  // Sequential fetch from reset
  localparam int stall_cycles   = 15;  // Redirect, random stalls, blocked write
  localparam int redir_cycles   = 3;
  localparam int train_cycles   = 6;
  localparam int halt_cycles    = 6;
  localparam int margin_cycles  = 20;
  localparam int total_cycles   = reset_cycles + seq_cycles + stall_cycles +
                                  redir_cycles + train_cycles + halt_cycles + margin_cycles;

  logic              clk = 1'b0;
  logic              rst;
  logic              stall;
  logic              update_pc_req;
  logic [addr_w-1:0] redirect_target;
  logic              wen_bht;
  logic              wen_btb;
  logic              resolved_taken;
  logic [addr_w-1:0] resolved_target;
  logic [addr_w-1:0] resolved_pc;
  logic [1:0]        resolved_prediction;
  logic [addr_w-1:0] pc_curr;
  logic [addr_w-1:0] pc_next;
  logic [inst_w-1:0] pc_inst;
  logic [1:0]        prediction;
  logic [addr_w-1:0] predicted_target;

  logic [inst_w-1:0] image [rom_words];  // Reference copy of the program
  logic [31:0]       lcg_state;
  string             current_test;
  int                test_errors;
  int                total_errors;
  int                tests_passed;
  int                tests_run;

  fetch_stage DUT (.*);

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcg_state;
  endfunction

  // Even address inside words 0..19, so never the HLT word
  function automatic logic [addr_w-1:0] random_target();
    logic [31:0] r;
    r = next_random();
    return addr_w'((r[23:16] % 20) * 2);
  endfunction

  function automatic logic [inst_w-1:0] image_word(input logic [addr_w-1:0] pc);
    if ((pc >> 1) < rom_words) return image[pc >> 1];
    return '0;  // Past the ROM
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_updates();
    update_pc_req  = 1'b0;
    wen_bht        = 1'b0;
    wen_btb        = 1'b0;
    resolved_taken = 1'b0;
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error %s: %s expected %h actual %h", current_test, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) tests_passed++;
    $display("%s: %s, %0d errors", current_test, (test_errors == 0) ? "pass" : "fail",
             test_errors);
  endtask

  task automatic steer_pc(input logic [addr_w-1:0] addr);
    update_pc_req   = 1'b1;
    redirect_target = addr;
    next_cycle();
    clear_updates();
  endtask

  // Train one entry and redirect the PC in the same cycle
  task automatic train_and_steer(input logic [addr_w-1:0] train_pc, input logic [1:0] count,
                                 input logic taken, input logic write_target,
                                 input logic [addr_w-1:0] target,
                                 input logic [addr_w-1:0] steer_addr);
    update_pc_req       = 1'b1;
    redirect_target     = steer_addr;
    wen_bht             = 1'b1;
    wen_btb             = write_target;  // BTB write always paired with BHT
    resolved_pc         = train_pc;
    resolved_prediction = count;
    resolved_taken      = taken;
    resolved_target     = target;
    next_cycle();
    clear_updates();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_sequential();
    logic [addr_w-1:0] exp_pc;
    current_test = "sequential";
    test_errors  = 0;
    exp_pc       = '0;
    for (int i = 0; i < seq_cycles; i++) begin
      @(negedge clk);
      check_value("pc_curr", exp_pc, pc_curr);
      check_value("pc_next", exp_pc + 2, pc_next);
      check_value("pc_inst", image_word(exp_pc), pc_inst);
      check_value("prediction", 0, prediction);  // Untrained tables
      next_cycle();
      exp_pc += 2;
    end
    report_test();
  endtask

  task automatic test_stall();
    logic [addr_w-1:0] exp_pc;
    logic [31:0]       r;
    current_test = "stall";
    test_errors  = 0;
    steer_pc('0);
    exp_pc = '0;
    for (int i = 0; i < 12; i++) begin
      r     = next_random();
      stall = r[20];
      @(negedge clk);
      check_value("pc_curr", exp_pc, pc_curr);
      check_value("pc_inst", stall ? 0 : image_word(exp_pc), pc_inst);
      next_cycle();
      if (!stall) exp_pc += 2;
    end
    // Taken training under stall must not reach the table
    stall               = 1'b1;
    wen_bht             = 1'b1;
    resolved_pc         = exp_pc;
    resolved_prediction = 2'd1;
    resolved_taken      = 1'b1;
    next_cycle();
    clear_updates();
    @(negedge clk);
    check_value("pc_curr", exp_pc, pc_curr);
    check_value("prediction", 0, prediction);
    check_value("pc_inst", 0, pc_inst);
    next_cycle();
    stall = 1'b0;
    report_test();
  endtask

  task automatic test_redirect();
    logic [addr_w-1:0] first_pc;
    logic [addr_w-1:0] second_pc;
    logic [addr_w-1:0] alt_target;
    current_test = "redirect";
    test_errors  = 0;
    first_pc     = random_target();
    second_pc    = random_target();
    alt_target   = random_target();
    // Make first_pc predict taken toward alt_target
    train_and_steer(first_pc, 2'd1, 1'b1, 1'b1, alt_target, first_pc);
    update_pc_req   = 1'b1;
    redirect_target = second_pc;
    @(negedge clk);
    check_value("pc_curr", first_pc, pc_curr);
    check_value("prediction", 2, prediction);
    check_value("predicted_target", alt_target, predicted_target);
    next_cycle();
    clear_updates();
    @(negedge clk);
    check_value("pc_curr", second_pc, pc_curr);  // Redirect beat the prediction
    train_and_steer(first_pc, 2'd1, 1'b0, 1'b0, '0, '0);  // Back to strongly not taken
    @(negedge clk);
    check_value("pc_curr", 0, pc_curr);
    report_test();
  endtask

  task automatic test_training();
    logic [31:0]       r;
    logic [addr_w-1:0] branch_pc;
    logic [addr_w-1:0] target;
    current_test = "training";
    test_errors  = 0;
    r            = next_random();
    branch_pc    = addr_w'((r[18:16]) * 2);  // One PC per predictor index
    target       = random_target();
    // 1 and taken gives 2
    train_and_steer(branch_pc, 2'd1, 1'b1, 1'b1, target, branch_pc);
    @(negedge clk);
    check_value("pc_curr", branch_pc, pc_curr);
    check_value("prediction", 2, prediction);
    check_value("predicted_target", target, predicted_target);
    next_cycle();
    @(negedge clk);
    check_value("pc_curr", target, pc_curr);
    // 2 and not taken gives 1, so fall through
    train_and_steer(branch_pc, 2'd2, 1'b0, 1'b0, '0, branch_pc);
    @(negedge clk);
    check_value("prediction", 1, prediction);
    next_cycle();
    @(negedge clk);
    check_value("pc_curr", branch_pc + 2, pc_curr);
    train_and_steer(branch_pc, 2'd3, 1'b1, 1'b0, '0, branch_pc);
    @(negedge clk);
    check_value("prediction sat high", 3, prediction);
    train_and_steer(branch_pc, 2'd0, 1'b0, 1'b0, '0, branch_pc);
    @(negedge clk);
    check_value("prediction sat low", 0, prediction);
    report_test();
  endtask

  task automatic test_halt();
    current_test = "halt";
    test_errors  = 0;
    steer_pc(16'd40);  // Word 20 holds HLT
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_value("pc_curr", 40, pc_curr);
      check_value("pc_inst", image_word(16'd40), pc_inst);
      next_cycle();
    end
    steer_pc('0);
    @(negedge clk);
    check_value("pc_curr", 0, pc_curr);
    report_test();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst                 = 1'b1;
    stall               = 1'b0;
    update_pc_req       = 1'b0;
    redirect_target     = '0;
    wen_bht             = 1'b0;
    wen_btb             = 1'b0;
    resolved_taken      = 1'b0;
    resolved_target     = '0;
    resolved_pc         = '0;
    resolved_prediction = '0;
    lcg_state           = 32'h490a;
    total_errors        = 0;
    tests_passed        = 0;
    tests_run           = 0;
    $readmemh(rom_image, image);
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
    test_sequential();
    test_stall();
    test_redirect();
    test_training();
    test_halt();
    $display("Summary: %0d tests, %0d passed, %0d errors", tests_run, tests_passed,
             total_errors);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(total_cycles * clk_period);
    $display("Timeout: tests did not finish within %0d cycles", total_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* source/program.hex */
// One 16-bit instruction word per line, word 0 first, top nibble is the opcode
1001
2102
3203
4304
5405
6506
7607
8708
9809
a90a
ba0b
cb0c
dc0d
ed0e
0e0f
1f10
2011
3112
4213
5314
f000
6415
7516
8617

/* all.f */
source/fetch_pkg.sv
source/predict_if.sv
source/branch_predictor.sv
source/inst_rom.sv
source/fetch_stage.sv
verif/tb_fetch.sv
